/* compile.f */
+incdir+include
design/soc_pkg.sv
design/bus_arbiter.sv
design/block_ram.sv
design/peripheral_bridge.sv
design/interval_timer.sv
design/dma_engine.sv
design/soc_top.sv
dv/tb_soc.sv

/* design/block_ram.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module block_ram (
	input logic clock,
	input logic i_request,
	input logic i_rw,
	input soc_pkg::addr_t i_address,
	input soc_pkg::data_t i_wdata,
	output soc_pkg::data_t o_rdata,
	output logic o_ready
);
	import soc_pkg::*;

	localparam int AW = $clog2(`SOC_RAM_WORDS);

	data_t mem [0:`SOC_RAM_WORDS-1];
	logic [AW-1:0] index;
	logic first;

	// Word index, byte offset dropped
	assign index = i_address[AW+1:2];

	// Only the first cycle of a held request counts
	assign first = i_request && !o_ready;

	always_ff @(posedge clock) begin
		o_ready <= first;
		if (first) begin
			if (i_rw) begin
				mem[index] <= i_wdata;
			end
			o_rdata <= mem[index];
		end
	end

endmodule

/* design/bus_arbiter.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module bus_arbiter (
	input logic clock,
	input logic i_rst,

	// Port A for instruction fetch
	input logic i_pa_request,
	input soc_pkg::addr_t i_pa_address,
	output logic o_pa_ready,
	output soc_pkg::data_t o_pa_rdata,

	// Port B for data access
	input logic i_pb_request,
	input logic i_pb_rw,
	input soc_pkg::addr_t i_pb_address,
	input soc_pkg::data_t i_pb_wdata,
	output logic o_pb_ready,
	output soc_pkg::data_t o_pb_rdata,

	// Port C for the DMA master
	input logic i_pc_request,
	input logic i_pc_rw,
	input soc_pkg::addr_t i_pc_address,
	input soc_pkg::data_t i_pc_wdata,
	output logic o_pc_ready,
	output soc_pkg::data_t o_pc_rdata,

	// Shared bus
	output logic o_bus_request,
	output logic o_bus_rw,
	output soc_pkg::addr_t o_bus_address,
	output soc_pkg::data_t o_bus_wdata,
	output soc_pkg::bus_source_t o_bus_source,
	input logic i_bus_ready,
	input soc_pkg::data_t i_bus_rdata
);
	import soc_pkg::*;

	arb_state_e state;
	bus_source_t grant;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			state <= ARB_IDLE;
			grant <= SRC_NONE;
		end else begin
			case (state)
				ARB_IDLE: begin
					// Fixed priority with instruction first
					if (i_pa_request) begin
						grant <= SRC_INSTR;
						state <= ARB_BUSY;
					end else if (i_pb_request) begin
						grant <= SRC_DATA;
						state <= ARB_BUSY;
					end else if (i_pc_request) begin
						grant <= SRC_DMA;
						state <= ARB_BUSY;
					end
				end
				ARB_BUSY: begin
					if (i_bus_ready) begin
						grant <= SRC_NONE;
						state <= ARB_IDLE;
					end
				end
				default: state <= ARB_IDLE;
			endcase
		end
	end

	// Capture the winner's access while idle
	always_ff @(posedge clock) begin
		if (state == ARB_IDLE) begin
			if (i_pa_request) begin
				o_bus_rw <= 1'b0;
				o_bus_address <= i_pa_address;
				o_bus_wdata <= '0;
			end else if (i_pb_request) begin
				o_bus_rw <= i_pb_rw;
				o_bus_address <= i_pb_address;
				o_bus_wdata <= i_pb_wdata;
			end else if (i_pc_request) begin
				o_bus_rw <= i_pc_rw;
				o_bus_address <= i_pc_address;
				o_bus_wdata <= i_pc_wdata;
			end
		end
	end

	assign o_bus_request = (state == ARB_BUSY);
	assign o_bus_source = grant;

	// Completion goes back to the granted port only
	assign o_pa_ready = o_bus_request && i_bus_ready && (grant == SRC_INSTR);
	assign o_pb_ready = o_bus_request && i_bus_ready && (grant == SRC_DATA);
	assign o_pc_ready = o_bus_request && i_bus_ready && (grant == SRC_DMA);

	assign o_pa_rdata = (grant == SRC_INSTR) ? i_bus_rdata : '0;
	assign o_pb_rdata = (grant == SRC_DATA) ? i_bus_rdata : '0;
	assign o_pc_rdata = (grant == SRC_DMA) ? i_bus_rdata : '0;

	// A completion only reaches a port that is still asking
	a_ready_to_requester: assert property (
		@(posedge clock) disable iff (i_rst)
		(!o_pa_ready || i_pa_request) &&
		(!o_pb_ready || i_pb_request) &&
		(!o_pc_ready || i_pc_request)
	);

endmodule

/* design/dma_engine.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module dma_engine (
	input logic clock,
	input logic i_rst,

	// Register port
	input logic i_request,
	input logic i_rw,
	input logic [1:0] i_reg,
	input soc_pkg::data_t i_wdata,
	output soc_pkg::data_t o_rdata,
	output logic o_ready,

	// Bus master
	output logic o_bus_request,
	output logic o_bus_rw,
	output soc_pkg::addr_t o_bus_address,
	output soc_pkg::data_t o_bus_wdata,
	input logic i_bus_ready,
	input soc_pkg::data_t i_bus_rdata
);
	import soc_pkg::*;

	dma_state_e state;
	addr_t source;
	addr_t destination;
	data_t words;
	data_t buffer;
	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			state <= DMA_IDLE;
			o_ready <= 1'b0;
			source <= '0;
			destination <= '0;
			words <= '0;
		end else begin
			o_ready <= access;
			case (state)
				DMA_IDLE: begin
					// Registers are only writable between transfers
					if (access && i_rw) begin
						case (i_reg)
							`SOC_DMA_REG_SOURCE: source <= i_wdata;
							`SOC_DMA_REG_DEST: destination <= i_wdata;
							`SOC_DMA_REG_COUNT: begin
								words <= i_wdata;
								if (i_wdata != '0) begin
									state <= DMA_READ;
								end
							end
							default: ;
						endcase
					end
				end
				DMA_READ: begin
					if (i_bus_ready) begin
						state <= DMA_WRITE;
					end
				end
				DMA_WRITE: begin
					if (i_bus_ready) begin
						source <= source + 32'd4;
						destination <= destination + 32'd4;
						words <= words - 1'b1;
						state <= (words == 32'd1) ? DMA_IDLE : DMA_READ;
					end
				end
				default: state <= DMA_IDLE;
			endcase
		end
	end

	// Word in flight
	always_ff @(posedge clock) begin
		if ((state == DMA_READ) && i_bus_ready) begin
			buffer <= i_bus_rdata;
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_reg)
				`SOC_DMA_REG_SOURCE: o_rdata <= source;
				`SOC_DMA_REG_DEST: o_rdata <= destination;
				`SOC_DMA_REG_COUNT: o_rdata <= words;
				`SOC_DMA_REG_BUSY: o_rdata <= {31'b0, state != DMA_IDLE};
			endcase
		end
	end

	assign o_bus_request = (state != DMA_IDLE);
	assign o_bus_rw = (state == DMA_WRITE);
	assign o_bus_address = (state == DMA_WRITE) ? destination : source;
	assign o_bus_wdata = buffer;

endmodule

/* design/interval_timer.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module interval_timer (
	input logic clock,
	input logic i_rst,
	input logic i_request,
	input logic i_rw,
	input logic [1:0] i_reg,
	input soc_pkg::data_t i_wdata,
	output soc_pkg::data_t o_rdata,
	output logic o_ready,
	output logic o_interrupt
);
	import soc_pkg::*;

	localparam int PW = $clog2(`SOC_TIMER_PRESCALE);
	localparam logic [PW-1:0] PRESCALE_LAST = PW'(`SOC_TIMER_PRESCALE - 1);

	logic [PW-1:0] prescale;
	data_t count;
	data_t compare;
	logic enable;
	logic access;

	assign access = i_request && !o_ready;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			o_ready <= 1'b0;
			prescale <= '0;
			count <= '0;
			compare <= '0;
			enable <= 1'b0;
		end else begin
			o_ready <= access;
			if (access && i_rw && (i_reg == `SOC_TIMER_REG_COMPARE)) begin
				// New compare restarts the interval
				compare <= i_wdata;
				count <= '0;
				prescale <= '0;
			end else if (enable) begin
				if (prescale == PRESCALE_LAST) begin
					prescale <= '0;
					count <= count + 1'b1;
				end else begin
					prescale <= prescale + 1'b1;
				end
			end
			if (access && i_rw && (i_reg == `SOC_TIMER_REG_ENABLE)) begin
				enable <= i_wdata[0];
			end
		end
	end

	always_ff @(posedge clock) begin
		if (access) begin
			case (i_reg)
				`SOC_TIMER_REG_COUNT: o_rdata <= count;
				`SOC_TIMER_REG_COMPARE: o_rdata <= compare;
				`SOC_TIMER_REG_ENABLE: o_rdata <= {31'b0, enable};
				default: o_rdata <= '0;
			endcase
		end
	end

	// Level, stays up until compare is rewritten or the timer is disabled
	assign o_interrupt = enable && (count >= compare);

endmodule

/* design/peripheral_bridge.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module peripheral_bridge (
	input logic clock,
	input logic i_rst,

	// Near side
	input logic i_request,
	input logic i_rw,
	input soc_pkg::far_addr_t i_address,
	input soc_pkg::data_t i_wdata,
	output soc_pkg::data_t o_rdata,
	output logic o_ready,
	output logic o_fault,

	// Far side
	output logic o_far_request,
	output logic o_far_rw,
	output soc_pkg::far_addr_t o_far_address,
	output soc_pkg::data_t o_far_wdata,
	output logic o_timer_select,
	output logic o_dma_select,
	input soc_pkg::data_t i_timer_rdata,
	input logic i_timer_ready,
	input soc_pkg::data_t i_dma_rdata,
	input logic i_dma_ready
);
	import soc_pkg::*;

	logic fault_ready;

	always_ff @(posedge clock) begin
		if (i_rst) begin
			o_far_request <= 1'b0;
			fault_ready <= 1'b0;
		end else begin
			if (o_far_request) begin
				if (o_ready) begin
					o_far_request <= 1'b0;
				end
			end else if (i_request) begin
				o_far_request <= 1'b1;
			end
			// Nobody answers an empty slot so the bridge completes it
			fault_ready <= o_far_request && !o_timer_select && !o_dma_select && !fault_ready;
		end
	end

	// Far side payload follows the near access
	always_ff @(posedge clock) begin
		if (!o_far_request && i_request) begin
			o_far_rw <= i_rw;
			o_far_address <= i_address;
			o_far_wdata <= i_wdata;
		end
	end

	// ========================================
	// Slot decode and return path
	// ========================================

	assign o_timer_select = (o_far_address[27:24] == `SOC_SLOT_TIMER);
	assign o_dma_select = (o_far_address[27:24] == `SOC_SLOT_DMA);

	assign o_rdata =
		o_timer_select ? i_timer_rdata :
		o_dma_select ? i_dma_rdata :
		'0;

	assign o_ready =
		o_timer_select ? i_timer_ready :
		o_dma_select ? i_dma_ready :
		fault_ready;

	assign o_fault = fault_ready;

	// Completion only while a far access is open
	a_ready_in_access: assert property (
		@(posedge clock) disable iff (i_rst)
		o_ready |-> o_far_request
	);

endmodule

/* design/soc_pkg.sv */
package soc_pkg;

	// ========================================
	// Bus vectors
	// ========================================

	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// Offset inside the bridge region
	typedef logic [27:0] far_addr_t;

	// Requesting port number
	typedef logic [1:0] bus_source_t;

	localparam bus_source_t SRC_NONE = 2'd0;
	localparam bus_source_t SRC_INSTR = 2'd1;
	localparam bus_source_t SRC_DATA = 2'd2;
	localparam bus_source_t SRC_DMA = 2'd3;

	// ========================================
	// State machines
	// ========================================

	typedef enum logic {
		ARB_IDLE,
		ARB_BUSY
	} arb_state_e;

	typedef enum logic [1:0] {
		DMA_IDLE,
		DMA_READ,
		DMA_WRITE
	} dma_state_e;

endpackage

/* design/soc_top.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module soc_top (
	input logic clock,
	input logic i_rst,

	// Instruction port
	input logic i_ibus_request,
	input soc_pkg::addr_t i_ibus_address,
	output logic o_ibus_ready,
	output soc_pkg::data_t o_ibus_rdata,

	// Data port
	input logic i_dbus_request,
	input logic i_dbus_rw,
	input soc_pkg::addr_t i_dbus_address,
	input soc_pkg::data_t i_dbus_wdata,
	output logic o_dbus_ready,
	output soc_pkg::data_t o_dbus_rdata,

	output logic o_timer_interrupt,

	// Fault report
	output logic o_bus_fault,
	output soc_pkg::addr_t o_bus_fault_address,
	output soc_pkg::bus_source_t o_bus_fault_source
);
	import soc_pkg::*;

	// Shared bus
	logic bus_request;
	logic bus_rw;
	logic bus_ready;
	addr_t bus_address;
	data_t bus_wdata;
	data_t bus_rdata;
	bus_source_t bus_source;

	// DMA as a master
	logic dma_bus_request;
	logic dma_bus_rw;
	logic dma_bus_ready;
	addr_t dma_bus_address;
	data_t dma_bus_wdata;
	data_t dma_bus_rdata;

	logic ram_select;
	logic bridge_select;
	logic near_fault_ready;
	data_t ram_rdata;
	logic ram_ready;
	data_t bridge_rdata;
	logic bridge_ready;
	logic bridge_fault;

	// Far side of the bridge
	logic far_request;
	logic far_rw;
	far_addr_t far_address;
	data_t far_wdata;
	logic timer_select;
	logic dma_select;
	data_t timer_rdata;
	logic timer_ready;
	data_t dma_rdata;
	logic dma_ready;

	bus_arbiter u_arbiter (
		.clock(clock),
		.i_rst(i_rst),
		.i_pa_request(i_ibus_request),
		.i_pa_address(i_ibus_address),
		.o_pa_ready(o_ibus_ready),
		.o_pa_rdata(o_ibus_rdata),
		.i_pb_request(i_dbus_request),
		.i_pb_rw(i_dbus_rw),
		.i_pb_address(i_dbus_address),
		.i_pb_wdata(i_dbus_wdata),
		.o_pb_ready(o_dbus_ready),
		.o_pb_rdata(o_dbus_rdata),
		.i_pc_request(dma_bus_request),
		.i_pc_rw(dma_bus_rw),
		.i_pc_address(dma_bus_address),
		.i_pc_wdata(dma_bus_wdata),
		.o_pc_ready(dma_bus_ready),
		.o_pc_rdata(dma_bus_rdata),
		.o_bus_request(bus_request),
		.o_bus_rw(bus_rw),
		.o_bus_address(bus_address),
		.o_bus_wdata(bus_wdata),
		.o_bus_source(bus_source),
		.i_bus_ready(bus_ready),
		.i_bus_rdata(bus_rdata)
	);

	// ========================================
	// Near side
	// ========================================

	assign ram_select = (bus_address[31:28] == `SOC_REGION_RAM);
	assign bridge_select = (bus_address[31:28] == `SOC_REGION_BRIDGE);

	block_ram u_ram (
		.clock(clock),
		.i_request(bus_request && ram_select),
		.i_rw(bus_rw),
		.i_address(bus_address),
		.i_wdata(bus_wdata),
		.o_rdata(ram_rdata),
		.o_ready(ram_ready)
	);

	peripheral_bridge u_bridge (
		.clock(clock),
		.i_rst(i_rst),
		.i_request(bus_request && bridge_select),
		.i_rw(bus_rw),
		.i_address(bus_address[27:0]),
		.i_wdata(bus_wdata),
		.o_rdata(bridge_rdata),
		.o_ready(bridge_ready),
		.o_fault(bridge_fault),
		.o_far_request(far_request),
		.o_far_rw(far_rw),
		.o_far_address(far_address),
		.o_far_wdata(far_wdata),
		.o_timer_select(timer_select),
		.o_dma_select(dma_select),
		.i_timer_rdata(timer_rdata),
		.i_timer_ready(timer_ready),
		.i_dma_rdata(dma_rdata),
		.i_dma_ready(dma_ready)
	);

	assign bus_ready =
		ram_select ? ram_ready :
		bridge_select ? bridge_ready :
		near_fault_ready;

	// Unmapped regions read as zero
	assign bus_rdata =
		ram_select ? ram_rdata :
		bridge_select ? bridge_rdata :
		'0;

	// ========================================
	// Far side
	// ========================================

	interval_timer u_timer (
		.clock(clock),
		.i_rst(i_rst),
		.i_request(far_request && timer_select),
		.i_rw(far_rw),
		.i_reg(far_address[3:2]),
		.i_wdata(far_wdata),
		.o_rdata(timer_rdata),
		.o_ready(timer_ready),
		.o_interrupt(o_timer_interrupt)
	);

	dma_engine u_dma (
		.clock(clock),
		.i_rst(i_rst),
		.i_request(far_request && dma_select),
		.i_rw(far_rw),
		.i_reg(far_address[3:2]),
		.i_wdata(far_wdata),
		.o_rdata(dma_rdata),
		.o_ready(dma_ready),
		.o_bus_request(dma_bus_request),
		.o_bus_rw(dma_bus_rw),
		.o_bus_address(dma_bus_address),
		.o_bus_wdata(dma_bus_wdata),
		.i_bus_ready(dma_bus_ready),
		.i_bus_rdata(dma_bus_rdata)
	);

	// ========================================
	// Faults
	// ========================================

	always_ff @(posedge clock) begin
		if (i_rst) begin
			near_fault_ready <= 1'b0;
			o_bus_fault_address <= '0;
			o_bus_fault_source <= SRC_NONE;
		end else begin
			near_fault_ready <= bus_request && !ram_select && !bridge_select && !near_fault_ready;
			// Follows the access in flight, so it is current by the ready cycle
			if (bus_request) begin
				o_bus_fault_address <= bus_address;
				o_bus_fault_source <= bus_source;
			end
		end
	end

	assign o_bus_fault = near_fault_ready || bridge_fault;

endmodule

/* dv/tb_soc.sv */
`timescale 1ns/10ps
`include "soc_macros.svh"

module tb_soc;
	import soc_pkg::*;

	// Tests need about 600 cycles together, this leaves a wide margin
	localparam int TIMEOUT_CYCLES = 4000;
	localparam int RAM_TEST_WORDS = 16;
	localparam int DMA_WORDS = 8;
	localparam int INTERRUPT_LIMIT = 5 * `SOC_TIMER_PRESCALE + 20;
	localparam bus_source_t SOURCE_DATA = 2'd2;

	localparam addr_t RAM_BASE = {`SOC_REGION_RAM, 28'h0};
	localparam addr_t TIMER_BASE = {`SOC_REGION_BRIDGE, `SOC_SLOT_TIMER, 24'h0};
	localparam addr_t DMA_BASE = {`SOC_REGION_BRIDGE, `SOC_SLOT_DMA, 24'h0};

	logic clock = 1'b0;
	logic i_rst;
	logic i_ibus_request;
	addr_t i_ibus_address;
	logic o_ibus_ready;
	data_t o_ibus_rdata;
	logic i_dbus_request;
	logic i_dbus_rw;
	addr_t i_dbus_address;
	data_t i_dbus_wdata;
	logic o_dbus_ready;
	data_t o_dbus_rdata;
	logic o_timer_interrupt;
	logic o_bus_fault;
	addr_t o_bus_fault_address;
	bus_source_t o_bus_fault_source;

	integer seed = 633;
	integer error_count = 0;
	integer check_count = 0;
	integer cycle_count = 0;

	data_t ram_words [RAM_TEST_WORDS];
	data_t dma_words [DMA_WORDS];
	data_t read_data;
	data_t data_a;
	data_t data_b;

	// Fault outputs as seen in the last data port ready cycle
	logic seen_fault;
	addr_t seen_fault_address;
	bus_source_t seen_fault_source;
	time ibus_done_time;
	time dbus_done_time;

	soc_top DUT (
		.clock(clock),
		.i_rst(i_rst),
		.i_ibus_request(i_ibus_request),
		.i_ibus_address(i_ibus_address),
		.o_ibus_ready(o_ibus_ready),
		.o_ibus_rdata(o_ibus_rdata),
		.i_dbus_request(i_dbus_request),
		.i_dbus_rw(i_dbus_rw),
		.i_dbus_address(i_dbus_address),
		.i_dbus_wdata(i_dbus_wdata),
		.o_dbus_ready(o_dbus_ready),
		.o_dbus_rdata(o_dbus_rdata),
		.o_timer_interrupt(o_timer_interrupt),
		.o_bus_fault(o_bus_fault),
		.o_bus_fault_address(o_bus_fault_address),
		.o_bus_fault_source(o_bus_fault_source)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: a test did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Checks: %0d, errors: %0d", check_count, error_count);
			$display("Simulation failed");
			$finish;
		end
	end

	// ========================================
	// Bus access and checking
	// ========================================

	task automatic check_value(input string what, input data_t actual, input data_t expected);
		check_count = check_count + 1;
		if (actual !== expected) begin
			error_count = error_count + 1;
			$display("ERR at %0t: %s, got %h, expected %h", $time, what, actual, expected);
		end
	endtask

	task automatic dbus_write(input addr_t address, input data_t data);
		@(posedge clock);
		i_dbus_request <= 1'b1;
		i_dbus_rw <= 1'b1;
		i_dbus_address <= address;
		i_dbus_wdata <= data;
		@(negedge clock);
		while (!o_dbus_ready) begin
			@(negedge clock);
		end
		@(posedge clock);
		i_dbus_request <= 1'b0;
		i_dbus_rw <= 1'b0;
	endtask

	task automatic dbus_read(input addr_t address, output data_t data);
		@(posedge clock);
		i_dbus_request <= 1'b1;
		i_dbus_rw <= 1'b0;
		i_dbus_address <= address;
		@(negedge clock);
		while (!o_dbus_ready) begin
			@(negedge clock);
		end
		data = o_dbus_rdata;
		seen_fault = o_bus_fault;
		seen_fault_address = o_bus_fault_address;
		seen_fault_source = o_bus_fault_source;
		dbus_done_time = $time;
		@(posedge clock);
		i_dbus_request <= 1'b0;
	endtask

	task automatic ibus_read(input addr_t address, output data_t data);
		@(posedge clock);
		i_ibus_request <= 1'b1;
		i_ibus_address <= address;
		@(negedge clock);
		while (!o_ibus_ready) begin
			@(negedge clock);
		end
		data = o_ibus_rdata;
		ibus_done_time = $time;
		@(posedge clock);
		i_ibus_request <= 1'b0;
	endtask

	// ========================================
	// Directed tests
	// ========================================

	task automatic ram_round_trip();
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			ram_words[i] = $random(seed);
			dbus_write(RAM_BASE + 32'h100 + 32'(4 * i), ram_words[i]);
		end
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			dbus_read(RAM_BASE + 32'h100 + 32'(4 * i), read_data);
			check_value("RAM read on data port", read_data, ram_words[i]);
		end
		for (int i = 0; i < RAM_TEST_WORDS; i++) begin
			ibus_read(RAM_BASE + 32'h100 + 32'(4 * i), read_data);
			check_value("RAM read on instruction port", read_data, ram_words[i]);
		end
	endtask

	task automatic port_contention();
		data_t word_a;
		data_t word_b;
		word_a = $random(seed);
		word_b = $random(seed);
		dbus_write(RAM_BASE + 32'h400, word_a);
		dbus_write(RAM_BASE + 32'h404, word_b);
		// Both ports raise request on the same edge
		fork
			ibus_read(RAM_BASE + 32'h400, data_a);
			dbus_read(RAM_BASE + 32'h404, data_b);
		join
		check_value("contention, instruction port data", data_a, word_a);
		check_value("contention, data port data", data_b, word_b);
		check_value("instruction port ready first", 32'(ibus_done_time < dbus_done_time), 1);
	endtask

	task automatic timer_interrupt();
		int waited;
		waited = 0;
		dbus_write(TIMER_BASE + 32'h4, 32'd5);
		dbus_write(TIMER_BASE + 32'h8, 32'd1);
		while (!o_timer_interrupt && waited < INTERRUPT_LIMIT) begin
			@(negedge clock);
			waited = waited + 1;
		end
		check_value("timer interrupt raised in time", 32'(o_timer_interrupt), 1);
		// Level output, must hold
		repeat (8) begin
			@(negedge clock);
			check_value("timer interrupt stays high", 32'(o_timer_interrupt), 1);
		end
		dbus_read(TIMER_BASE, read_data);
		check_value("timer count at least compare", 32'(read_data >= 32'd5), 1);
	endtask

	task automatic dma_copy();
		data_t busy;
		for (int i = 0; i < DMA_WORDS; i++) begin
			dma_words[i] = $random(seed);
			dbus_write(RAM_BASE + 32'h200 + 32'(4 * i), dma_words[i]);
		end
		dbus_write(DMA_BASE, RAM_BASE + 32'h200);
		dbus_write(DMA_BASE + 32'h4, RAM_BASE + 32'h300);
		dbus_write(DMA_BASE + 32'h8, DMA_WORDS);
		busy = 32'd1;
		while (busy != 32'd0) begin
			dbus_read(DMA_BASE + 32'hc, busy);
		end
		for (int i = 0; i < DMA_WORDS; i++) begin
			dbus_read(RAM_BASE + 32'h300 + 32'(4 * i), read_data);
			check_value("DMA destination word", read_data, dma_words[i]);
		end
		// Source pointer moves one word per copy
		dbus_read(DMA_BASE, read_data);
		check_value("DMA source after copy", read_data, RAM_BASE + 32'h200 + 32'(4 * DMA_WORDS));
	endtask

	task automatic fault_reporting();
		addr_t address;
		address = 32'h7000_0010;
		dbus_read(address, read_data);
		check_value("unmapped region data", read_data, 32'd0);
		check_value("unmapped region fault", 32'(seen_fault), 1);
		check_value("unmapped region fault address", seen_fault_address, address);
		check_value("unmapped region fault source", 32'(seen_fault_source), 32'(SOURCE_DATA));

		address = {`SOC_REGION_BRIDGE, 4'h3, 24'h20};
		dbus_read(address, read_data);
		check_value("empty slot data", read_data, 32'd0);
		check_value("empty slot fault", 32'(seen_fault), 1);
		check_value("empty slot fault address", seen_fault_address, address);
		check_value("empty slot fault source", 32'(seen_fault_source), 32'(SOURCE_DATA));

		dbus_read(RAM_BASE + 32'h100, read_data);
		check_value("RAM read after fault, data", read_data, ram_words[0]);
		check_value("RAM read after fault, no fault", 32'(seen_fault), 0);
	endtask

	initial begin
		i_rst = 1'b1;
		i_ibus_request = 1'b0;
		i_ibus_address = '0;
		i_dbus_request = 1'b0;
		i_dbus_rw = 1'b0;
		i_dbus_address = '0;
		i_dbus_wdata = '0;
		repeat (2) @(posedge clock);
		i_rst <= 1'b0;

		ram_round_trip();
		port_contention();
		timer_interrupt();
		dma_copy();
		fault_reporting();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

/* include/soc_macros.svh */
`ifndef SOC_MACROS_SVH
`define SOC_MACROS_SVH

// ========================================
// Address map
// ========================================

// Near side regions, address bits 31:28
`define SOC_REGION_RAM 4'h2
`define SOC_REGION_BRIDGE 4'h5

// Far side slots behind the bridge, address bits 27:24
`define SOC_SLOT_TIMER 4'h5
`define SOC_SLOT_DMA 4'h7

// ========================================
// Sizes and rates
// ========================================

`define SOC_RAM_WORDS 1024
`define SOC_TIMER_PRESCALE 4

// Timer register word offsets
`define SOC_TIMER_REG_COUNT 2'd0
`define SOC_TIMER_REG_COMPARE 2'd1
`define SOC_TIMER_REG_ENABLE 2'd2

// DMA register word offsets
`define SOC_DMA_REG_SOURCE 2'd0
`define SOC_DMA_REG_DEST 2'd1
`define SOC_DMA_REG_COUNT 2'd2
`define SOC_DMA_REG_BUSY 2'd3

`endif

/* run_sim.sh */
#!/usr/bin/env bash
# Build the SoC testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal --top-module tb_soc \
	-f compile.f -o tb_soc_sim > build.log 2>&1 \
	&& ./obj_dir/tb_soc_sim > sim.log 2>&1 \
	|| { echo "Build or run error, see build.log and sim.log"; exit 1; }

# The testbench prints its pass line only when every check held
grep -q "Simulation completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL, see sim.log"; exit 1; }
